// ==== logic/cacheGeomPkg.sv ====
// cache geometry for the four-way 68k read cache
// way, set and word counts, tag width
// address-field view of the cpu address, tag entry, lru bits and way masks

package cacheGeomPkg;

	////////////////////////////////////////////////////////////////////////////
	// geometry
	////////////////////////////////////////////////////////////////////////////
	localparam int NumWays   = 4;		// fixed by the three-bit lru tree
	localparam int NumSets   = 8;
	localparam int LineWords = 8;		// 16-bit words per line
	localparam int TagWidth  = 25;		// a31..a7

	typedef logic [1:0] wayIdx_t;
	typedef logic [NumWays-1:0] wayMask_t;	// one bit per way
	typedef logic [2:0] setIdx_t;
	typedef logic [2:0] wordIdx_t;
	typedef logic [2:0] lruBits_t;		// bit0 picks the half, bit1 ways 0/1, bit2 ways 2/3

	// cpu byte address split into cache fields
	typedef struct packed {
		logic [TagWidth-1:0] tag;
		setIdx_t set;
		wordIdx_t word;
		logic byteSel;			// a0, unused by word fills
	} cacheAddr_t;

	// one tag store entry
	typedef struct packed {
		logic valid;
		logic [TagWidth-1:0] tag;
	} tagEntry_t;

endpackage

// ==== logic/busPkg.sv ====
// bus side types for the 68k cache
// data word, cpu request bundle, dram controller request and status

package busPkg;

	typedef logic [15:0] word_t;

	// request from the 68000 toward the cache
	typedef struct packed {
		logic AS_L;			// address strobe
		logic UDS_L;			// upper byte strobe, d15..d8
		logic LDS_L;			// lower byte strobe, d7..d0
		logic WE_L;			// low for write
		logic DramSelect_H;		// address decodes to dram
		logic [31:0] address;
		word_t wrData;
	} cpuBus_t;

	// request from the cache toward the dram controller
	typedef struct packed {
		logic select_L;			// kicks the dram controller
		logic AS_L;
		logic UDS_L;
		logic LDS_L;
		logic WE_L;
		logic [31:0] address;		// line aligned on fills
		word_t wrData;
	} dramReq_t;

	// status back from the dram controller
	typedef struct packed {
		logic Dtack_L;
		logic CAS_L;			// low with ras high marks a read burst start
		logic RAS_L;			// low with cas low is a refresh
	} dramStat_t;

endpackage

// ==== logic/burstCounter.sv ====
// free running counter with synchronous clear
// set address during the sweep, word address during a burst fill

`timescale 1ns/1ps

module burstCounter #(
	parameter int CountWidth = 3
) (
	input logic Clock,
	input logic Reset_L,
	input logic countClear,
	output logic [CountWidth-1:0] count
);

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L)
			count <= '0;
		else if (countClear)
			count <= '0;			// zero in the cycle after clear
		else
			count <= count + 1'b1;		// wraps when left running
	end

endmodule

// ==== logic/plruPolicy.sv ====
// tree pseudo-lru replacement
// per-set tree store, working copy, victim choice and victim register

`timescale 1ns/1ps

module plruPolicy
	import cacheGeomPkg::*;
(
	input logic Clock,
	input logic Reset_L,
	input setIdx_t setIdx,
	input logic loadLru,
	input logic pickVictim,
	input logic touchHit,
	input logic clearAll,
	input wayMask_t hitMask,
	input wayMask_t validMask,
	output wayIdx_t victimWay,
	output logic setFull
);

	lruBits_t lruStore [NumSets];	// three tree bits per set
	lruBits_t lruWork;		// copy of the addressed set
	lruBits_t lruNext;
	wayIdx_t treeWay;		// way the tree points at
	wayIdx_t firstFree;		// lowest invalid way
	wayIdx_t chosenWay;
	wayIdx_t hitWay;
	wayIdx_t usedWay;

	assign setFull   = &validMask;
	assign chosenWay = setFull ? treeWay : firstFree;
	assign usedWay   = (|hitMask) ? hitWay : chosenWay;	// hit wins over replacement

	always_comb begin
		if (!lruWork[0])
			treeWay = lruWork[1] ? 2'd1 : 2'd0;	// left half
		else
			treeWay = lruWork[2] ? 2'd3 : 2'd2;	// right half
		firstFree = 2'd0;
		hitWay    = 2'd0;
		for (int w = NumWays - 1; w >= 0; w--) begin
			if (!validMask[w])
				firstFree = wayIdx_t'(w);	// lowest index ends up last
			if (hitMask[w])
				hitWay = wayIdx_t'(w);
		end
	end

	// point the tree away from the way just used
	always_comb begin
		case (usedWay)
			2'd0: lruNext = {lruWork[2], 2'b11};
			2'd1: lruNext = {lruWork[2], 2'b01};
			2'd2: lruNext = {1'b1, lruWork[1], 1'b0};
			default: lruNext = {1'b0, lruWork[1], 1'b0};
		endcase
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			lruWork   <= '0;
			victimWay <= '0;
			for (int s = 0; s < NumSets; s++)
				lruStore[s] <= '0;
		end else begin
			if (clearAll) begin
				for (int s = 0; s < NumSets; s++)
					lruStore[s] <= '0;
			end else if (touchHit) begin
				lruStore[setIdx] <= lruNext;
			end
			if (loadLru)
				lruWork <= lruStore[setIdx];
			if (pickVictim)
				victimWay <= chosenWay;		// held for the whole fill
		end
	end

endmodule

// ==== logic/wayStore.sv ====
// four-way storage array, one write enable per way
// payload type and depth set by the instantiating module

`timescale 1ns/1ps

module wayStore
	import cacheGeomPkg::*;
#(
	parameter type T = logic [15:0],
	parameter int Depth = 8
) (
	input logic Clock,
	input logic Reset_L,
	input logic [$clog2(Depth)-1:0] addr,
	input wayMask_t we,
	input T wrData,
	output T rdData [NumWays]
);

	T mem [NumWays][Depth];

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			for (int w = 0; w < NumWays; w++)
				for (int d = 0; d < Depth; d++)
					mem[w][d] <= '0;
		end else begin
			for (int w = 0; w < NumWays; w++)
				if (we[w])
					mem[w][addr] <= wrData;	// same entry in every enabled way
		end
	end

	always_comb begin
		for (int w = 0; w < NumWays; w++)
			rdData[w] = mem[w][addr];		// combinational read
	end

endmodule

// ==== logic/cacheArrays.sv ====
// tag and data stores of the cache
// valid qualified tag compare per way, word select toward the cpu

`timescale 1ns/1ps

module cacheArrays
	import cacheGeomPkg::*;
	import busPkg::*;
#(
	parameter int TagDepth = 8,
	parameter int DataDepth = 64
) (
	input logic Clock,
	input logic Reset_L,
	input setIdx_t setIdx,
	input wordIdx_t wordIdx,
	input logic [TagWidth-1:0] reqTag,
	input wayMask_t tagWe,
	input wayMask_t dataWe,
	input logic validOut,
	input word_t fillData,
	output wayMask_t hitMask,
	output wayMask_t validMask,
	output word_t cpuData
);

	localparam int TagAddrW  = $clog2(TagDepth);
	localparam int DataAddrW = $clog2(DataDepth);

	tagEntry_t tagRd [NumWays];
	word_t dataRd [NumWays];
	tagEntry_t tagWr;
	logic [TagAddrW-1:0] tagAddr;
	logic [DataAddrW-1:0] dataAddr;

	assign tagWr    = '{valid: validOut, tag: reqTag};
	assign tagAddr  = TagAddrW'(setIdx);
	assign dataAddr = DataAddrW'({setIdx, wordIdx});	// set major, word minor

	wayStore #(
		.T(tagEntry_t),
		.Depth(TagDepth)
	) tagStore (
		.Clock(Clock),
		.Reset_L(Reset_L),
		.addr(tagAddr),
		.we(tagWe),
		.wrData(tagWr),
		.rdData(tagRd)
	);

	wayStore #(
		.T(word_t),
		.Depth(DataDepth)
	) dataStore (
		.Clock(Clock),
		.Reset_L(Reset_L),
		.addr(dataAddr),
		.we(dataWe),
		.wrData(fillData),			// burst words straight from dram
		.rdData(dataRd)
	);

	// after a fill the new tag is valid, so the filled way shows up as the hit
	always_comb begin
		cpuData = '0;
		for (int w = 0; w < NumWays; w++) begin
			validMask[w] = tagRd[w].valid;
			hitMask[w]   = tagRd[w].valid && (tagRd[w].tag == reqTag);
			if (hitMask[w])
				cpuData = cpuData | dataRd[w];	// at most one way hits
		end
	end

endmodule

// ==== logic/cacheSequencer.sv ====
// cache controller fsm
// invalidate sweep after reset, hit check, line fill from dram,
// write-through, and the strobes toward both buses

`timescale 1ns/1ps

module cacheSequencer
	import cacheGeomPkg::*;
	import busPkg::*;
#(
	parameter int CountWidth = 3
) (
	input logic Clock,
	input logic Reset_L,
	input cpuBus_t cpuReq,
	output logic DtackTo68k_L,
	output dramReq_t dramReq,
	input dramStat_t dramStat,
	input logic [CountWidth-1:0] count,
	output logic countClear,
	output logic loadLru,
	output logic pickVictim,
	output logic touchHit,
	output logic clearAll,
	input logic setFull,
	input wayIdx_t victimWay,
	output setIdx_t setIdx,
	output wordIdx_t wordIdx,
	output wayMask_t tagWe,
	output wayMask_t dataWe,
	output logic validOut,
	input wayMask_t hitMask,
	input wayMask_t validMask
);

	typedef enum logic [3:0] {
		Reset,
		Invalidate,
		Idle,
		CheckHit,
		FillRequest,
		CasWait1,
		CasWait2,
		BurstFill,
		EndFill,
		WriteThrough,
		HoldHit
	} seqState_t;

	localparam logic [CountWidth-1:0] LastSet  = CountWidth'(NumSets - 1);
	localparam logic [CountWidth-1:0] LastWord = CountWidth'(LineWords - 1);

	seqState_t state;
	seqState_t nextState;
	cacheAddr_t cpuAddr;		// cpu address as tag/set/word
	wayMask_t victimMask;		// one-hot of the way being filled
	logic anyHit;
	logic cpuRequest;
	logic cycleDone;
	logic casStart;

	assign cpuAddr    = cacheAddr_t'(cpuReq.address);
	assign victimMask = wayMask_t'(4'b0001 << victimWay);
	assign anyHit     = |hitMask;			// hit mask is already valid qualified
	assign cpuRequest = !cpuReq.AS_L && cpuReq.DramSelect_H;
	assign cycleDone  = cpuReq.AS_L || !cpuReq.DramSelect_H;	// 68k ended its bus cycle
	assign casStart   = !dramStat.CAS_L && dramStat.RAS_L;	// read, not refresh

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L)
			state <= Reset;
		else
			state <= nextState;
	end

	////////////////////////////////////////////////////////////////////////////
	// next state and outputs
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		nextState        = state;
		DtackTo68k_L     = 1'b1;			// no dtack until data is ready
		dramReq.select_L = 1'b1;			// dram left alone unless needed
		dramReq.AS_L     = cpuReq.AS_L;		// strobes pass through by default
		dramReq.UDS_L    = cpuReq.UDS_L;
		dramReq.LDS_L    = cpuReq.LDS_L;
		dramReq.WE_L     = cpuReq.WE_L;
		dramReq.address  = {cpuAddr.tag, cpuAddr.set, 4'b0000};	// line aligned
		dramReq.wrData   = cpuReq.wrData;
		countClear       = 1'b0;
		loadLru          = 1'b0;
		pickVictim       = 1'b0;
		touchHit         = 1'b0;
		clearAll         = 1'b0;
		setIdx           = cpuAddr.set;
		wordIdx          = cpuAddr.word;
		tagWe            = '0;
		dataWe           = '0;
		validOut         = 1'b0;

		case (state)
			Reset: begin
				countClear = 1'b1;			// sweep starts at set 0
				nextState  = Invalidate;
			end

			// one set per cycle, all ways at once
			Invalidate: begin
				setIdx   = setIdx_t'(count);
				tagWe    = '1;
				validOut = 1'b0;
				clearAll = 1'b1;			// tree bits back to zero
				if (count == LastSet)
					nextState = Idle;
			end

			Idle: begin
				if (cpuRequest) begin
					loadLru = 1'b1;			// working copy of this set's tree
					if (cpuReq.WE_L) begin
						dramReq.UDS_L = 1'b0;	// reads always fetch both bytes
						dramReq.LDS_L = 1'b0;
						nextState     = CheckHit;
					end else begin
						dramReq.select_L = 1'b0;
						tagWe     = hitMask;	// drop only the way that holds the line
						validOut  = 1'b0;
						nextState = WriteThrough;
					end
				end
			end

			CheckHit: begin
				dramReq.UDS_L = 1'b0;
				dramReq.LDS_L = 1'b0;
				if (anyHit) begin
					DtackTo68k_L = 1'b0;		// word from the hitting way
					touchHit     = 1'b1;
					nextState    = HoldHit;
				end else begin
					dramReq.select_L = 1'b0;	// start the dram read early
					pickVictim = 1'b1;
					touchHit   = setFull;		// tree moves only on eviction
					nextState  = FillRequest;
				end
			end

			HoldHit: begin
				dramReq.UDS_L = 1'b0;
				dramReq.LDS_L = 1'b0;
				DtackTo68k_L  = 1'b0;
				if (cycleDone)
					nextState = Idle;
			end

			// wait here through refreshes until the read cas shows up
			FillRequest: begin
				dramReq.UDS_L    = 1'b0;
				dramReq.LDS_L    = 1'b0;
				dramReq.select_L = 1'b0;
				tagWe    = victimMask;		// claim the line for the new tag
				validOut = 1'b1;
				if (casStart)
					nextState = CasWait1;
			end

			CasWait1: begin				// first cas latency clock
				dramReq.UDS_L    = 1'b0;
				dramReq.LDS_L    = 1'b0;
				dramReq.select_L = 1'b0;
				nextState        = CasWait2;
			end

			CasWait2: begin				// second cas latency clock
				dramReq.UDS_L    = 1'b0;
				dramReq.LDS_L    = 1'b0;
				dramReq.select_L = 1'b0;
				countClear       = 1'b1;		// word 0 arrives next cycle
				nextState        = BurstFill;
			end

			BurstFill: begin
				dramReq.UDS_L    = 1'b0;
				dramReq.LDS_L    = 1'b0;
				dramReq.select_L = 1'b0;
				wordIdx = wordIdx_t'(count);	// burst word address
				dataWe  = victimMask;
				if (count == LastWord)
					nextState = EndFill;
			end

			// line is in, hand the cpu its own word
			EndFill: begin
				dramReq.UDS_L = 1'b0;
				dramReq.LDS_L = 1'b0;
				DtackTo68k_L  = 1'b0;
				if (cycleDone)
					nextState = Idle;
			end

			WriteThrough: begin
				dramReq.address  = cpuReq.address;	// full byte address for writes
				dramReq.select_L = 1'b0;
				DtackTo68k_L     = dramStat.Dtack_L;	// dram decides the latency
				if (cycleDone)
					nextState = Idle;
			end

			default: nextState = Reset;
		endcase
	end

endmodule

// ==== logic/m68kCacheTop.sv ====
// top level of the 68k four-way read cache
// sequencer, burst counter, lru policy and the tag/data arrays

`timescale 1ns/1ps

module m68kCacheTop
	import cacheGeomPkg::*;
	import busPkg::*;
(
	input logic Clock,
	input logic Reset_L,
	input cpuBus_t cpuReq,
	output word_t cpuData,
	output logic DtackTo68k_L,
	output dramReq_t dramReq,
	input dramStat_t dramStat,
	input word_t dramData
);

	localparam int CountWidth = $clog2(LineWords);	// also covers the set sweep
	localparam int TagDepth   = NumSets;
	localparam int DataDepth  = NumSets * LineWords;

	logic [CountWidth-1:0] count;
	logic countClear;
	logic loadLru;
	logic pickVictim;
	logic touchHit;
	logic clearAll;
	logic setFull;
	logic validOut;
	wayIdx_t victimWay;
	setIdx_t setIdx;
	wordIdx_t wordIdx;
	wayMask_t tagWe;
	wayMask_t dataWe;
	wayMask_t hitMask;
	wayMask_t validMask;

	cacheSequencer #(.CountWidth(CountWidth)) sequencer (
		.Clock(Clock), .Reset_L(Reset_L),
		.cpuReq(cpuReq), .DtackTo68k_L(DtackTo68k_L),
		.dramReq(dramReq), .dramStat(dramStat),
		.count(count), .countClear(countClear),
		.loadLru(loadLru), .pickVictim(pickVictim),
		.touchHit(touchHit), .clearAll(clearAll),
		.setFull(setFull), .victimWay(victimWay),
		.setIdx(setIdx), .wordIdx(wordIdx),
		.tagWe(tagWe), .dataWe(dataWe), .validOut(validOut),
		.hitMask(hitMask), .validMask(validMask)
	);

	burstCounter #(.CountWidth(CountWidth)) counter (
		.Clock(Clock), .Reset_L(Reset_L),
		.countClear(countClear), .count(count)
	);

	plruPolicy policy (
		.Clock(Clock), .Reset_L(Reset_L),
		.setIdx(setIdx), .loadLru(loadLru),
		.pickVictim(pickVictim), .touchHit(touchHit), .clearAll(clearAll),
		.hitMask(hitMask), .validMask(validMask),
		.victimWay(victimWay), .setFull(setFull)
	);

	cacheArrays #(.TagDepth(TagDepth), .DataDepth(DataDepth)) arrays (
		.Clock(Clock), .Reset_L(Reset_L),
		.setIdx(setIdx), .wordIdx(wordIdx),
		.reqTag(cpuReq.address[31 -: TagWidth]),	// a31..a7
		.tagWe(tagWe), .dataWe(dataWe), .validOut(validOut),
		.fillData(dramData),
		.hitMask(hitMask), .validMask(validMask),
		.cpuData(cpuData)
	);

endmodule

// ==== test/m68kCacheTop_props.sv ====
// bound assertions on the cache sequencer
// dtack idle level, no dram select while holding a hit,
// tag and data stores never written in the same cycle

`timescale 1ns/1ps

module m68kCacheTop_props
	import cacheGeomPkg::*;
(
	input logic Clock,
	input logic Reset_L,
	input logic inIdle,
	input logic inHoldHit,
	input logic cpuAS_L,
	input logic DtackTo68k_L,
	input logic dramSelect_L,
	input wayMask_t tagWe,
	input wayMask_t dataWe
);

	int failCount = 0;			// read by the testbench at the end

	idleDtack: assert property (@(posedge Clock) disable iff (!Reset_L)
		(inIdle && cpuAS_L) |-> DtackTo68k_L)
		else begin
			failCount++;
			$error("Dtack low in Idle while AS_L is high");
		end

	holdNoSelect: assert property (@(posedge Clock) disable iff (!Reset_L)
		inHoldHit |-> dramSelect_L)
		else begin
			failCount++;
			$error("dram select low during HoldHit");
		end

	// the tag is claimed before the burst, never together with it
	storeWrites: assert property (@(posedge Clock) disable iff (!Reset_L)
		!((|tagWe) && (|dataWe)))
		else begin
			failCount++;
			$error("tag and data stores written in the same cycle");
		end

endmodule

bind cacheSequencer m68kCacheTop_props props (
	.Clock(Clock), .Reset_L(Reset_L),
	.inIdle(state == Idle), .inHoldHit(state == HoldHit),
	.cpuAS_L(cpuReq.AS_L), .DtackTo68k_L(DtackTo68k_L),
	.dramSelect_L(dramReq.select_L),
	.tagWe(tagWe), .dataWe(dataWe)
);

// ==== test/m68kCacheTop_tb.sv ====
// testbench for the 68k four-way read cache
// clock and reset, dram controller model with random cas and dtack delays,
// cpu read and write cycles from the test data file, typed compare tasks

`timescale 1ns/1ps

module m68kCacheTop_tb
	import cacheGeomPkg::*;
	import busPkg::*;
();

	localparam int MaxOps        = 64;
	localparam int TimeoutCycles = 200;	// per wait loop

	logic Clock;
	logic Reset_L;
	cpuBus_t cpuReq;
	word_t cpuData;
	logic DtackTo68k_L;
	dramReq_t dramReq;
	dramStat_t dramStat;
	word_t dramData;

	logic [31:0] testData [4*MaxOps];	// op, address, data, miss per line
	word_t dramMem [logic [31:0]];		// words written into the dram model
	word_t expMem [logic [31:0]];		// words the cpu has written
	int fillCount = 0;			// bursts started by the model
	int writeCount = 0;
	logic [31:0] lastFillAddr;
	logic [31:0] lastWriteAddr;
	word_t lastWriteData;
	logic timedOut = 1'b0;
	int wordErrors = 0;
	int flagErrors = 0;
	int addrErrors = 0;
	int otherErrors = 0;

	m68kCacheTop UUT (
		.Clock(Clock), .Reset_L(Reset_L),
		.cpuReq(cpuReq), .cpuData(cpuData), .DtackTo68k_L(DtackTo68k_L),
		.dramReq(dramReq), .dramStat(dramStat), .dramData(dramData)
	);

	initial Clock = 1'b0;
	always #5 Clock = ~Clock;		// 10 ns period

	// initial dram contents, every address bit plays a part
	function automatic word_t fillPattern(input logic [31:0] a);
		return a[15:0] ^ {a[23:16], a[31:24]} ^ 16'h6c1d;
	endfunction

	function automatic word_t readDram(input logic [31:0] a);
		if (dramMem.exists(a))
			return dramMem[a];
		return fillPattern(a);
	endfunction

	function automatic word_t expectedWord(input logic [31:0] a);
		if (expMem.exists(a))
			return expMem[a];
		return fillPattern(a);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////
	task automatic compareWord(input string name, input word_t got, input word_t expected);
		if (got !== expected) begin
			wordErrors++;
			$display("ERR %s got %h expected %h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic compareFlag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			flagErrors++;
			$display("ERR %s got %h expected %h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic compareAddr(input string name, input cacheAddr_t got,
			input cacheAddr_t expected);
		if (got !== expected) begin
			addrErrors++;
			$display("ERR %s got %h expected %h (tag %h set %h word %h) at %0t",
				name, got, expected, expected.tag, expected.set, expected.word, $time);
		end
	endtask

	// every cycle here moves a whole word, so address and both byte strobes are low
	task automatic checkDramStrobes();
		compareFlag("dramReq.AS_L", dramReq.AS_L, 1'b0);
		compareFlag("dramReq.UDS_L", dramReq.UDS_L, 1'b0);
		compareFlag("dramReq.LDS_L", dramReq.LDS_L, 1'b0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// dram controller model
	////////////////////////////////////////////////////////////////////////////
	initial begin : dramModel
		logic [31:0] lineAddr;
		int delay;
		int held;
		void'($urandom(32'hf2f9_d70a));	// only user of random numbers
		dramStat.Dtack_L = 1'b1;
		dramStat.CAS_L   = 1'b1;
		dramStat.RAS_L   = 1'b1;
		dramData         = '0;
		forever begin
			@(negedge Clock);
			if (Reset_L && dramReq.select_L == 1'b0) begin
				if (dramReq.WE_L) begin
					lineAddr     = {dramReq.address[31:4], 4'h0};
					lastFillAddr = dramReq.address;
					fillCount++;
					checkDramStrobes();
					delay = int'($urandom_range(3, 0));
					@(posedge Clock);
					repeat (delay) @(posedge Clock);
					#1 dramStat.CAS_L = 1'b0;		// read cas, ras stays high
					@(posedge Clock);
					#1 dramStat.CAS_L = 1'b1;
					repeat (2) @(posedge Clock);	// cas latency
					for (int w = 0; w < LineWords; w++) begin
						#1 dramData = readDram(lineAddr + 32'(2 * w));
						@(posedge Clock);
					end
				end else begin
					delay = int'($urandom_range(4, 1));
					repeat (delay) @(negedge Clock);	// sequencer now in write-through
					lastWriteAddr = dramReq.address;
					lastWriteData = dramReq.wrData;
					checkDramStrobes();
					dramMem[{dramReq.address[31:1], 1'b0}] = dramReq.wrData;
					writeCount++;
					@(posedge Clock);
					#1 dramStat.Dtack_L = 1'b0;
					held = 0;
					while (dramReq.select_L == 1'b0 && held < TimeoutCycles) begin
						@(negedge Clock);
						held++;
					end
					@(posedge Clock);
					#1 dramStat.Dtack_L = 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// cpu side
	////////////////////////////////////////////////////////////////////////////
	task automatic releaseBus();
		cpuReq.AS_L         = 1'b1;
		cpuReq.UDS_L        = 1'b1;
		cpuReq.LDS_L        = 1'b1;
		cpuReq.WE_L         = 1'b1;
		cpuReq.DramSelect_H = 1'b0;
	endtask

	// sampled at the falling edge, away from the fill's last write
	task automatic waitDtack();
		int waited;
		waited = 0;
		do begin
			@(negedge Clock);
			waited++;
		end while (DtackTo68k_L !== 1'b0 && waited < TimeoutCycles);
		if (DtackTo68k_L !== 1'b0) begin
			timedOut = 1'b1;
			otherErrors++;
			$display("timeout: the cache gave no Dtack within %0d cycles at %0t", waited, $time);
		end
	endtask

	task automatic readWord(input logic [31:0] addr, input logic expMiss);
		int fillsBefore;
		word_t got;
		fillsBefore = fillCount;
		@(posedge Clock);
		#1;
		cpuReq.address      = addr;
		cpuReq.WE_L         = 1'b1;
		cpuReq.UDS_L        = 1'b0;
		cpuReq.LDS_L        = 1'b0;
		cpuReq.DramSelect_H = 1'b1;
		cpuReq.AS_L         = 1'b0;
		waitDtack();
		got = cpuData;
		@(posedge Clock);
		#1 releaseBus();
		if (!timedOut) begin
			compareWord("cpuData", got, expectedWord({addr[31:1], 1'b0}));
			compareFlag("miss", fillCount != fillsBefore, expMiss);
			if (expMiss && fillCount != fillsBefore)
				compareAddr("dramReq.address", lastFillAddr, {addr[31:4], 4'h0});
		end
		repeat (3) @(posedge Clock);		// idle gap between bus cycles
	endtask

	task automatic writeWord(input logic [31:0] addr, input word_t data, input logic expMiss);
		int fillsBefore;
		int writesBefore;
		logic ackSeen;
		fillsBefore  = fillCount;
		writesBefore = writeCount;
		@(posedge Clock);
		#1;
		cpuReq.address      = addr;
		cpuReq.wrData       = data;
		cpuReq.WE_L         = 1'b0;
		cpuReq.UDS_L        = 1'b0;
		cpuReq.LDS_L        = 1'b0;
		cpuReq.DramSelect_H = 1'b1;
		cpuReq.AS_L         = 1'b0;
		waitDtack();
		ackSeen = dramStat.Dtack_L;		// cpu dtack must come from dram
		@(posedge Clock);
		#1 releaseBus();
		expMem[{addr[31:1], 1'b0}] = data;
		if (!timedOut) begin
			compareFlag("dramStat.Dtack_L", ackSeen, 1'b0);
			compareFlag("miss", fillCount != fillsBefore, expMiss);
			compareAddr("dramReq.address", lastWriteAddr, addr);
			compareWord("dramReq.wrData", lastWriteData, data);
			if (writeCount != writesBefore + 1) begin
				otherErrors++;
				$display("the write at %h did not reach the dram model", addr);
			end
		end
		repeat (3) @(posedge Clock);		// lets the model raise its dtack
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin : stimulus
		int i;
		int opsRun;
		int totalErrors;
		logic [31:0] opCode;
		Reset_L        = 1'b0;
		cpuReq.address = '0;
		cpuReq.wrData  = '0;
		releaseBus();
		opsRun = 0;
		$readmemh("test/m68kCacheTop_testdata.txt", testData);
		repeat (3) @(posedge Clock);
		#1 Reset_L = 1'b1;
		repeat (12) @(posedge Clock);		// invalidate sweep ends in cycle ten
		for (i = 0; i < MaxOps; i++) begin
			opCode = testData[4*i];
			if ($isunknown(opCode) || opCode == 32'hf || timedOut)
				break;
			case (opCode)
				32'h0: readWord(testData[4*i+1], testData[4*i+3][0]);
				32'h1: writeWord(testData[4*i+1], testData[4*i+2][15:0], testData[4*i+3][0]);
				default: begin
					otherErrors++;
					$display("unknown operation %h on test data line %0d", opCode, i);
				end
			endcase
			opsRun++;
		end
		if (opsRun == 0) begin
			otherErrors++;
			$display("no transactions were read from the test data file");
		end
		totalErrors = wordErrors + flagErrors + addrErrors + otherErrors
			+ UUT.sequencer.props.failCount;
		$display("%0d transactions, errors word %0d flag %0d addr %0d other %0d assert %0d",
			opsRun, wordErrors, flagErrors, addrErrors, otherErrors,
			UUT.sequencer.props.failCount);
		if (totalErrors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== test/m68kCacheTop_testdata.txt ====
// columns: op address data miss, all hex; op 0 read, 1 write, f ends the list
// data is the word written by a write, miss is 1 when a line fill is expected
0 00001000 0000 1
0 00001002 0000 0
0 00001004 0000 0
0 00001006 0000 0
0 00001008 0000 0
0 0000100a 0000 0
0 0000100c 0000 0
0 0000100e 0000 0
0 00002010 0000 1
1 00002014 beef 0
0 00002014 0000 1
0 00002012 0000 0
1 00003028 1234 0
0 00003028 0000 1
// set 5: four fills, a fifth tag evicts way 0, then the first four again
0 00008050 0000 1
0 000080d0 0000 1
0 00008150 0000 1
0 000081d0 0000 1
0 00008250 0000 1
0 00008050 0000 1
0 000080d0 0000 0
0 00008150 0000 1
0 000081d0 0000 1
// set 6: a miss at each word address
0 00010060 0000 1
0 000100e2 0000 1
0 00010164 0000 1
0 000101e6 0000 1
0 00010268 0000 1
0 000102ea 0000 1
0 0001036c 0000 1
0 000103ee 0000 1
f 00000000 0000 0

// ==== m68kCacheTop.f ====
logic/cacheGeomPkg.sv
logic/busPkg.sv
logic/burstCounter.sv
logic/plruPolicy.sv
logic/wayStore.sv
logic/cacheArrays.sv
logic/cacheSequencer.sv
logic/m68kCacheTop.sv
test/m68kCacheTop_props.sv
test/m68kCacheTop_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module m68kCacheTop_tb \
	-f m68kCacheTop.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vm68kCacheTop_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^All checks passed$" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1
